// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_issue_stage
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --assert --timing -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --assert --timing --top-module $(TOP)
PASS_MSG   := TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -q "^$(PASS_MSG)$$"; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
rtl/isa_pkg.sv
rtl/issue_pkg.sv
rtl/pair_decoder.sv
rtl/issue_buffer.sv
rtl/issue_select.sv
rtl/reg_file.sv
rtl/issue_stage_top.sv
test/issue_stage_props.sv
test/tb_issue_stage.sv

// ==== rtl/isa_pkg.sv ====
package isa_pkg;

    ////////////////////////////////////////
    // field widths
    ////////////////////////////////////////
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W      = 16;
    localparam int OPCODE_W   = 6;

    // lsb position of each field in the word
    localparam int OPCODE_LSB = 26;
    localparam int RD_LSB     = 21;
    localparam int RS1_LSB    = 16;
    localparam int RS2_LSB    = 11;
    localparam int IMM_LSB    = 0;   // overlaps rs2

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [IMM_W-1:0]      imm_t;
    typedef logic [OPCODE_W-1:0]   opcode_t;

    ////////////////////////////////////////
    // opcodes
    ////////////////////////////////////////
    localparam opcode_t OP_NOP  = 6'h00;
    localparam opcode_t OP_ADD  = 6'h01;
    localparam opcode_t OP_SUB  = 6'h02;
    localparam opcode_t OP_ADDI = 6'h03; // rd = rs1 + imm
    localparam opcode_t OP_LD   = 6'h04;
    localparam opcode_t OP_ST   = 6'h05; // mem[rs1 + imm] = rs2
    localparam opcode_t OP_BEQ  = 6'h06;

    // operation class seen by the issue logic
    typedef enum logic [2:0] {
        CLS_NOP, CLS_ALU, CLS_LOAD, CLS_STORE, CLS_BRANCH
    } op_class_e;

endpackage

// ==== rtl/issue_buffer.sv ====
`timescale 1ns/1ps

module issue_buffer (
    input  logic                   clk,
    input  logic                   rstn,
    input  issue_pkg::slot_t       i_slot_a,   // older of the pair
    input  issue_pkg::slot_t       i_slot_b,
    input  issue_pkg::issue_num_t  i_pop_num,
    input  logic                   i_flush,
    output issue_pkg::slot_t       o_head_a,   // oldest entry
    output issue_pkg::slot_t       o_head_b,
    output issue_pkg::issue_num_t  o_avail,
    output logic                   o_full
);
    import issue_pkg::*;

    slot_t      mem [BUF_DEPTH];

    buf_ptr_t   head;        // next entry to issue
    buf_ptr_t   tail;        // next entry to write
    buf_ptr_t   head_p1;
    buf_ptr_t   tail_p1;
    buf_count_t count;

    issue_num_t push_num;
    buf_count_t count_left;  // after this edge's pop, before the push
    buf_count_t count_next;
    issue_num_t avail_next;

    ////////////////////////////////////////
    // occupancy bookkeeping
    ////////////////////////////////////////
    assign push_num   = i_slot_a.valid ? (i_slot_b.valid ? 2'd2 : 2'd1) : 2'd0;
    assign count_left = count - buf_count_t'(i_pop_num);
    assign count_next = count_left + buf_count_t'(push_num);
    assign avail_next = (count_next >= buf_count_t'(2)) ? 2'd2 : count_next[1:0];

    assign head_p1 = head + buf_ptr_t'(1); // wraps at BUF_DEPTH
    assign tail_p1 = tail + buf_ptr_t'(1);

    ////////////////////////////////////////
    // entry storage
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_slot_a.valid) begin
            mem[tail] <= i_slot_a;
        end
        if (i_slot_a.valid && i_slot_b.valid) begin
            mem[tail_p1] <= i_slot_b;
        end
    end

    ////////////////////////////////////////
    // pointers and flags
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            o_avail <= '0;
            o_full  <= 1'b0;
        end else if (i_flush) begin
            // pushes in the flush cycle are dropped too
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            o_avail <= '0;
            o_full  <= 1'b0;
        end else begin
            head    <= head + buf_ptr_t'(i_pop_num);
            tail    <= tail + buf_ptr_t'(push_num);
            count   <= count_next;
            o_avail <= avail_next;
            o_full  <= (count_left >= buf_count_t'(BUF_FULL_LEVEL));
        end
    end

    // the two oldest entries, qualified by o_avail
    assign o_head_a = mem[head];
    assign o_head_b = mem[head_p1];

endmodule

// ==== rtl/issue_pkg.sv ====
package issue_pkg;

    ////////////////////////////////////////
    // issue buffer sizing
    ////////////////////////////////////////
    localparam int BUF_DEPTH      = 16;
    localparam int BUF_FULL_LEVEL = BUF_DEPTH - 6; // slack for fetch in flight
    localparam int BUF_PTR_W      = $clog2(BUF_DEPTH);

    typedef logic [BUF_PTR_W-1:0] buf_ptr_t;
    typedef logic [BUF_PTR_W:0]   buf_count_t; // holds 0 .. BUF_DEPTH
    typedef logic [1:0]           issue_num_t; // 0, 1 or 2 slots

    // one decoded instruction waiting for issue
    typedef struct packed {
        logic                valid;
        logic                illegal;
        isa_pkg::word_t      pc;
        isa_pkg::op_class_e  op;
        isa_pkg::opcode_t    opcode;
        isa_pkg::reg_addr_t  rd;
        isa_pkg::reg_addr_t  rs1;
        isa_pkg::reg_addr_t  rs2;
        logic                rf_we;
        logic                uses_rs2;
        isa_pkg::imm_t       imm;
    } slot_t;

    // issued slot with its operands attached
    typedef struct packed {
        slot_t               slot;
        isa_pkg::word_t      src1;
        isa_pkg::word_t      src2;
    } issued_t;

endpackage

// ==== rtl/issue_select.sv ====
`timescale 1ns/1ps

module issue_select (
    input  issue_pkg::slot_t       i_head_a,
    input  issue_pkg::slot_t       i_head_b,
    input  issue_pkg::issue_num_t  i_avail,
    input  logic                   i_stall,
    output issue_pkg::issue_num_t  o_issue_num
);
    import isa_pkg::*;

    logic a_ok;
    logic b_ok;
    logic a_is_mem;
    logic b_is_mem;
    logic a_writes;
    logic raw_hazard;

    ////////////////////////////////////////
    // pairing rules for lane b
    ////////////////////////////////////////
    assign a_is_mem = (i_head_a.op == CLS_LOAD) || (i_head_a.op == CLS_STORE);
    assign b_is_mem = (i_head_b.op == CLS_LOAD) || (i_head_b.op == CLS_STORE);

    // r0 is never a real destination
    assign a_writes = i_head_a.rf_we && (i_head_a.rd != '0);

    // b reads rs1 always, rs2 only if it uses it
    assign raw_hazard = a_writes &&
                        ((i_head_b.rs1 == i_head_a.rd) ||
                         (i_head_b.uses_rs2 && (i_head_b.rs2 == i_head_a.rd)));

    assign a_ok = (i_avail != 2'd0) && !i_stall;

    assign b_ok = a_ok &&
                  (i_avail == 2'd2) &&
                  (i_head_a.op != CLS_BRANCH) &&  // nothing pairs behind a branch
                  !(a_is_mem && b_is_mem) &&      // single memory port
                  !raw_hazard;

    assign o_issue_num = b_ok ? 2'd2 : (a_ok ? 2'd1 : 2'd0);

endmodule

// ==== rtl/issue_stage_top.sv ====
`timescale 1ns/1ps

module issue_stage_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [1:0]             i_fetch_valid,
    input  isa_pkg::word_t         i_fetch_pc,
    input  isa_pkg::word_t         i_fetch_word_a,
    input  isa_pkg::word_t         i_fetch_word_b,
    input  logic                   i_flush,
    input  logic                   i_stall,
    input  logic                   i_wb_we,
    input  isa_pkg::reg_addr_t     i_wb_addr,
    input  isa_pkg::word_t         i_wb_data,
    output logic                   o_full,
    output issue_pkg::issue_num_t  o_issue_num,
    output issue_pkg::issued_t     o_issue_a,
    output issue_pkg::issued_t     o_issue_b   // valid only when o_issue_num is 2
);
    import isa_pkg::*;
    import issue_pkg::*;

    slot_t      slot_a;
    slot_t      slot_b;
    slot_t      head_a;
    slot_t      head_b;
    issue_num_t avail;
    word_t      rdata_a1;
    word_t      rdata_a2;
    word_t      rdata_b1;
    word_t      rdata_b2;

    ////////////////////////////////////////
    // fetch -> decode -> buffer
    ////////////////////////////////////////
    pair_decoder u_decoder (
        .i_fetch_valid  (i_fetch_valid),
        .i_fetch_pc     (i_fetch_pc),
        .i_fetch_word_a (i_fetch_word_a),
        .i_fetch_word_b (i_fetch_word_b),
        .o_slot_a       (slot_a),
        .o_slot_b       (slot_b)
    );

    issue_buffer u_buffer (
        .clk       (clk),
        .rstn      (rstn),
        .i_slot_a  (slot_a),
        .i_slot_b  (slot_b),
        .i_pop_num (o_issue_num),   // pops at the next edge
        .i_flush   (i_flush),
        .o_head_a  (head_a),
        .o_head_b  (head_b),
        .o_avail   (avail),
        .o_full    (o_full)
    );

    issue_select u_select (
        .i_head_a    (head_a),
        .i_head_b    (head_b),
        .i_avail     (avail),
        .i_stall     (i_stall),
        .o_issue_num (o_issue_num)
    );

    ////////////////////////////////////////
    // operand read, one port pair per lane
    ////////////////////////////////////////
    reg_file u_rf (
        .clk        (clk),
        .rstn       (rstn),
        .i_raddr_a1 (head_a.rs1),
        .i_raddr_a2 (head_a.rs2),
        .i_raddr_b1 (head_b.rs1),
        .i_raddr_b2 (head_b.rs2),
        .i_we       (i_wb_we),
        .i_waddr    (i_wb_addr),
        .i_wdata    (i_wb_data),
        .o_rdata_a1 (rdata_a1),
        .o_rdata_a2 (rdata_a2),
        .o_rdata_b1 (rdata_b1),
        .o_rdata_b2 (rdata_b2)
    );

    assign o_issue_a = '{slot: head_a, src1: rdata_a1, src2: rdata_a2};
    assign o_issue_b = '{slot: head_b, src1: rdata_b1, src2: rdata_b2};

endmodule

// ==== rtl/pair_decoder.sv ====
`timescale 1ns/1ps

module pair_decoder (
    input  logic [1:0]        i_fetch_valid,  // bit 1 is the older word
    input  isa_pkg::word_t    i_fetch_pc,
    input  isa_pkg::word_t    i_fetch_word_a,
    input  isa_pkg::word_t    i_fetch_word_b,
    output issue_pkg::slot_t  o_slot_a,
    output issue_pkg::slot_t  o_slot_b
);
    import isa_pkg::*;
    import issue_pkg::*;

    word_t pc_b;

    function automatic slot_t decode(input logic vld, input word_t pc, input word_t word);
        slot_t   s;
        opcode_t opc;
        opc        = word[OPCODE_LSB +: OPCODE_W];
        s.valid    = vld;
        s.illegal  = 1'b0;
        s.pc       = pc;
        s.op       = CLS_NOP;
        s.opcode   = opc;
        s.rd       = word[RD_LSB +: REG_ADDR_W];
        s.rs1      = word[RS1_LSB +: REG_ADDR_W];
        s.rs2      = word[RS2_LSB +: REG_ADDR_W];
        s.rf_we    = 1'b0;
        s.uses_rs2 = 1'b0;
        s.imm      = word[IMM_LSB +: IMM_W];
        case (opc)
            OP_NOP: s.op = CLS_NOP;
            OP_ADD, OP_SUB: begin
                s.op       = CLS_ALU;
                s.rf_we    = 1'b1;
                s.uses_rs2 = 1'b1;
            end
            OP_ADDI: begin
                s.op    = CLS_ALU;
                s.rf_we = 1'b1;
            end
            OP_LD: begin
                s.op    = CLS_LOAD;
                s.rf_we = 1'b1;
            end
            OP_ST: begin
                s.op       = CLS_STORE;
                s.uses_rs2 = 1'b1; // store data
            end
            OP_BEQ: begin
                s.op       = CLS_BRANCH;
                s.uses_rs2 = 1'b1;
            end
            default: s.illegal = 1'b1; // stays a nop with no writeback
        endcase
        return s;
    endfunction

    assign pc_b = i_fetch_pc + word_t'(4);

    assign o_slot_a = decode(i_fetch_valid[1], i_fetch_pc, i_fetch_word_a);
    assign o_slot_b = decode(i_fetch_valid[0], pc_b, i_fetch_word_b);

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                clk,
    input  logic                rstn,
    input  isa_pkg::reg_addr_t  i_raddr_a1,
    input  isa_pkg::reg_addr_t  i_raddr_a2,
    input  isa_pkg::reg_addr_t  i_raddr_b1,
    input  isa_pkg::reg_addr_t  i_raddr_b2,
    input  logic                i_we,
    input  isa_pkg::reg_addr_t  i_waddr,
    input  isa_pkg::word_t      i_wdata,
    output isa_pkg::word_t      o_rdata_a1,
    output isa_pkg::word_t      o_rdata_a2,
    output isa_pkg::word_t      o_rdata_b1,
    output isa_pkg::word_t      o_rdata_b2
);
    import isa_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // combinational reads, old value during a write
    assign o_rdata_a1 = (i_raddr_a1 == '0) ? '0 : regs[i_raddr_a1];
    assign o_rdata_a2 = (i_raddr_a2 == '0) ? '0 : regs[i_raddr_a2];
    assign o_rdata_b1 = (i_raddr_b1 == '0) ? '0 : regs[i_raddr_b1];
    assign o_rdata_b2 = (i_raddr_b2 == '0) ? '0 : regs[i_raddr_b2];

endmodule

// ==== test/issue_stage_props.sv ====
`timescale 1ns/1ps

module issue_stage_props (
    input logic                   clk,
    input logic                   rstn,
    input issue_pkg::buf_count_t  i_count,
    input issue_pkg::issue_num_t  i_pop_num,  // the select output
    input issue_pkg::issue_num_t  i_avail,
    input logic                   i_flush,
    input logic                   i_full
);
    import issue_pkg::*;

    ////////////////////////////////////////
    // occupancy and pop bounds
    ////////////////////////////////////////
    a_count_max: assert property (@(posedge clk) disable iff (!rstn)
        i_count <= buf_count_t'(BUF_DEPTH))
        else $error("buffer occupancy above its depth");

    a_pop_le_avail: assert property (@(posedge clk) disable iff (!rstn)
        i_pop_num <= i_avail)
        else $error("pop count larger than the valid head entries");

    // flush leaves nothing to issue in the next cycle
    a_flush_quiet: assert property (@(posedge clk) disable iff (!rstn)
        i_flush |=> (i_avail == 2'd0 && i_pop_num == 2'd0 && !i_full))
        else $error("issue or full flag still active after a flush");

endmodule

bind issue_buffer issue_stage_props u_props (
    .clk       (clk),
    .rstn      (rstn),
    .i_count   (count),
    .i_pop_num (i_pop_num),
    .i_avail   (o_avail),
    .i_flush   (i_flush),
    .i_full    (o_full)
);

// ==== test/tb_issue_stage.sv ====
`timescale 1ns/1ps

module tb_issue_stage;
    import isa_pkg::*;
    import issue_pkg::*;

    localparam int          CLK_PERIOD      = 10;
    localparam int          RESET_CYCLES    = 10;
    localparam int          STIM_CYCLES     = 3000;
    localparam int          WATCHDOG_CYCLES = RESET_CYCLES + STIM_CYCLES + 1000;
    localparam logic [31:0] SEED            = 32'h0293bf49;

    logic       clk;
    logic       rstn;
    logic [1:0] i_fetch_valid;
    word_t      i_fetch_pc;
    word_t      i_fetch_word_a;
    word_t      i_fetch_word_b;
    logic       i_flush;
    logic       i_stall;
    logic       i_wb_we;
    reg_addr_t  i_wb_addr;
    word_t      i_wb_data;
    logic       o_full;
    issue_num_t o_issue_num;
    issued_t    o_issue_a;
    issued_t    o_issue_b;

    slot_t ref_q[$];     // expected buffer contents, oldest first
    word_t regs_m [32];  // register file mirror
    logic  exp_full;
    int    n_dual;
    int    n_full;

    issue_stage_top UUT (
        .clk            (clk),
        .rstn           (rstn),
        .i_fetch_valid  (i_fetch_valid),
        .i_fetch_pc     (i_fetch_pc),
        .i_fetch_word_a (i_fetch_word_a),
        .i_fetch_word_b (i_fetch_word_b),
        .i_flush        (i_flush),
        .i_stall        (i_stall),
        .i_wb_we        (i_wb_we),
        .i_wb_addr      (i_wb_addr),
        .i_wb_data      (i_wb_data),
        .o_full         (o_full),
        .o_issue_num    (o_issue_num),
        .o_issue_a      (o_issue_a),
        .o_issue_b      (o_issue_b)
    );

    ////////////////////////////////////////
    // reference decode and pairing rule
    ////////////////////////////////////////
    function automatic slot_t decode_word(input word_t pc, input word_t w);
        slot_t   s;
        opcode_t opc;
        opc      = w[31:26];
        s        = '0;  // class nop, no flags
        s.valid  = 1'b1;
        s.pc     = pc;
        s.opcode = opc;
        s.rd     = w[25:21];
        s.rs1    = w[20:16];
        s.rs2    = w[15:11];
        s.imm    = w[15:0];
        case (opc)
            OP_ADD, OP_SUB, OP_ADDI: s.op = CLS_ALU;
            OP_LD:   s.op = CLS_LOAD;
            OP_ST:   s.op = CLS_STORE;
            OP_BEQ:  s.op = CLS_BRANCH;
            OP_NOP:  s.op = CLS_NOP;
            default: s.illegal = 1'b1;
        endcase
        s.rf_we    = (s.op == CLS_ALU) || (s.op == CLS_LOAD);
        s.uses_rs2 = (opc == OP_ADD) || (opc == OP_SUB) ||
                     (opc == OP_ST) || (opc == OP_BEQ);
        return s;
    endfunction

    function automatic int pair_count(input slot_t a, input slot_t b, input int n,
                                      input logic stall);
        logic hazard;
        logic both_mem;
        hazard   = a.rf_we && (a.rd != 5'd0) &&
                   ((b.rs1 == a.rd) || (b.uses_rs2 && (b.rs2 == a.rd)));
        both_mem = (a.op inside {CLS_LOAD, CLS_STORE}) && (b.op inside {CLS_LOAD, CLS_STORE});
        if (stall || n == 0)
            return 0;
        if (n == 1 || a.op == CLS_BRANCH || hazard || both_mem)
            return 1;
        return 2;
    endfunction

    function automatic word_t make_word();
        word_t w;
        int    pick;
        w    = $urandom;
        pick = $urandom % 15;
        case (pick % 7)
            0: w[31:26] = OP_NOP;
            1: w[31:26] = OP_ADD;
            2: w[31:26] = OP_SUB;
            3: w[31:26] = OP_ADDI;
            4: w[31:26] = OP_LD;
            5: w[31:26] = OP_ST;
            default: w[31:26] = OP_BEQ;
        endcase
        if (pick == 14)
            w[31:26] = opcode_t'($urandom_range(16, 63)); // outside the defined opcodes
        w[25:21] = reg_addr_t'($urandom % 8); // few registers, so hazards show up
        w[20:16] = reg_addr_t'($urandom % 8);
        w[15:11] = reg_addr_t'($urandom % 8);
        return w;
    endfunction

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    ////////////////////////////////////////
    // per-cycle stimulus, check and model
    ////////////////////////////////////////
    task automatic drive_inputs(input int cyc);
        int r;
        int stall_pct;
        stall_pct      = ((cyc / 250) % 2 == 1) ? 75 : 20; // fill phases and drain phases
        r              = $urandom % 3;
        i_fetch_valid  = (o_full || r == 0) ? 2'b00 : ((r == 1) ? 2'b10 : 2'b11);
        i_fetch_pc     = word_t'($urandom) & ~word_t'(3);
        i_fetch_word_a = make_word();
        i_fetch_word_b = make_word();
        i_stall        = (($urandom % 100) < stall_pct);
        i_flush        = (($urandom % 64) == 0);
        i_wb_we        = (($urandom % 2) == 1);
        i_wb_addr      = reg_addr_t'($urandom);
        i_wb_data      = $urandom;
    endtask

    task automatic check_cycle(output int exp_num);
        int    exp_avail;
        slot_t a;
        slot_t b;
        a         = '0;
        b         = '0;
        exp_avail = (ref_q.size() > 2) ? 2 : ref_q.size();
        if (ref_q.size() > 0)
            a = ref_q[0];
        if (ref_q.size() > 1)
            b = ref_q[1];
        exp_num = pair_count(a, b, exp_avail, i_stall);
        assert (int'(UUT.avail) == exp_avail)
            else report_error($sformatf("o_avail %0d, expected %0d", UUT.avail, exp_avail));
        assert (int'(o_issue_num) == exp_num)
            else report_error($sformatf("issue count %0d, expected %0d", o_issue_num, exp_num));
        assert (o_full == exp_full)
            else report_error($sformatf("o_full %0b, expected %0b", o_full, exp_full));
        if (exp_num >= 1) begin
            assert (o_issue_a.slot == a)
                else report_error($sformatf("lane a record wrong, pc %h", a.pc));
            assert (o_issue_a.src1 == regs_m[a.rs1] && o_issue_a.src2 == regs_m[a.rs2])
                else report_error($sformatf("lane a operands wrong, pc %h", a.pc));
        end
        if (exp_num == 2) begin
            assert (o_issue_b.slot == b)
                else report_error($sformatf("lane b record wrong, pc %h", b.pc));
            assert (o_issue_b.src1 == regs_m[b.rs1] && o_issue_b.src2 == regs_m[b.rs2])
                else report_error($sformatf("lane b operands wrong, pc %h", b.pc));
            n_dual++;
        end
        if (o_full)
            n_full++;
    endtask

    task automatic update_model(input int num);
        if (i_flush) begin
            ref_q.delete();  // flush also drops this cycle's pushes
            exp_full = 1'b0;
        end else begin
            repeat (num) ref_q.delete(0);
            exp_full = (ref_q.size() >= BUF_FULL_LEVEL); // registered, seen next cycle
            if (i_fetch_valid[1])
                ref_q.push_back(decode_word(i_fetch_pc, i_fetch_word_a));
            if (i_fetch_valid[0])
                ref_q.push_back(decode_word(i_fetch_pc + word_t'(4), i_fetch_word_b));
        end
        if (i_wb_we && i_wb_addr != 5'd0)
            regs_m[i_wb_addr] = i_wb_data; // reads this cycle saw the old value
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("watchdog expired before the stimulus loop finished");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        int num;
        void'($urandom(SEED));
        rstn           = 1'b0;
        i_fetch_valid  = 2'b00;
        i_fetch_pc     = '0;
        i_fetch_word_a = '0;
        i_fetch_word_b = '0;
        i_flush        = 1'b0;
        i_stall        = 1'b0;
        i_wb_we        = 1'b0;
        i_wb_addr      = '0;
        i_wb_data      = '0;
        exp_full       = 1'b0;
        n_dual         = 0;
        n_full         = 0;
        foreach (regs_m[i])
            regs_m[i] = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rstn = 1'b1;
        for (int cyc = 0; cyc < STIM_CYCLES; cyc++) begin
            drive_inputs(cyc);
            #2;  // outputs settled, well before the rising edge
            check_cycle(num);
            update_model(num);
            @(negedge clk);
        end
        if (n_dual == 0 || n_full == 0) begin
            $display("stimulus never reached a dual issue or a full buffer");
            $display("TEST FAILED");
            $fatal(1, "stimulus too weak");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule
